// File: Makefile
# Verilator build and run of the crtc testbench

SIM  = obj_dir/Vcrtc_tb
SRCS = $(shell cat vlog.f)

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module crtc_tb \
		-f vlog.f -o Vcrtc_tb

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: hdl/crtc_address.sv
// crtc address generator: framestore address, scanline row and cursor decode
`default_nettype none

module crtc_address import crtc_pkg::*; #(
	parameter int FS_ADDR_W = crtc_pkg::FS_ADDR_W
) (
	input  logic                 char_clk,
	input  logic                 nRESET,
	input  crtc_cfg_t            cfg,
	input  crtc_beat_t           beat,
	input  logic                 display_en,
	output logic [FS_ADDR_W-1:0] framestore_adr,
	output logic [4:0]           scanline_row,
	output logic                 cursor
);

	logic [FS_ADDR_W-1:0] row_start;
	logic [FS_ADDR_W-1:0] row_step;
	logic [FS_ADDR_W-1:0] next_row_start;
	logic                 cursor_point;
	logic                 cursor_rows;

	assign row_step       = FS_ADDR_W'(cfg.horz_display);
	assign next_row_start = row_start + row_step;

	// one character per clock, back to the row start on each scanline
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			framestore_adr <= '0;
		end else if (beat.frame_end) begin
			framestore_adr <= FS_ADDR_W'(cfg.start_address);
		end else if (beat.row_end) begin
			framestore_adr <= next_row_start;
		end else if (beat.scanline_end) begin
			framestore_adr <= row_start;
		end else begin
			framestore_adr <= framestore_adr + 1'b1;
		end
	end

	// row start picked up from the live address on the first clock of a frame
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			row_start <= '0;
		end else if (beat.row_end && !beat.frame_end) begin
			row_start <= next_row_start;
		end else if (beat.first_line) begin
			row_start <= framestore_adr;
		end
	end

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			scanline_row <= '0;
		end else if (beat.frame_end || beat.row_end) begin
			scanline_row <= '0;
		end else if (beat.scanline_end) begin
			scanline_row <= scanline_row + 5'd1;
		end
	end

	assign cursor_point = (framestore_adr == FS_ADDR_W'(cfg.cursor_adr));
	assign cursor_rows  = (scanline_row >= cfg.cursor_start_row) &&
		(scanline_row <= cfg.cursor_end_row);

	// mode 01 hides the cursor, any other mode is steady
	assign cursor = display_en & cursor_point & cursor_rows & (cfg.cursor_mode != 2'b01);

endmodule

`default_nettype wire

// File: hdl/crtc_pkg.sv
// crtc shared definitions: register indices, register image, timing events, video and bus types
`default_nettype none

package crtc_pkg;

	// framestore address width, overridable at the top level
	localparam int FS_ADDR_W = 14;

	// 6845 register indices
	localparam logic [4:0] REG_R0_HTOTAL     = 5'd0;
	localparam logic [4:0] REG_R1_HDISP      = 5'd1;
	localparam logic [4:0] REG_R2_HSYNCPOS   = 5'd2;
	localparam logic [4:0] REG_R3_SYNCWIDTH  = 5'd3;
	localparam logic [4:0] REG_R4_VTOTAL     = 5'd4;
	localparam logic [4:0] REG_R5_VTADJ      = 5'd5;
	localparam logic [4:0] REG_R6_VDISP      = 5'd6;
	localparam logic [4:0] REG_R7_VSYNCPOS   = 5'd7;
	localparam logic [4:0] REG_R8_INTERLACE  = 5'd8;
	localparam logic [4:0] REG_R9_MAXSCAN    = 5'd9;
	localparam logic [4:0] REG_R10_CUR_START = 5'd10;
	localparam logic [4:0] REG_R11_CUR_END   = 5'd11;
	localparam logic [4:0] REG_R12_START_HI  = 5'd12;
	localparam logic [4:0] REG_R13_START_LO  = 5'd13;
	localparam logic [4:0] REG_R14_CUR_HI    = 5'd14;
	localparam logic [4:0] REG_R15_CUR_LO    = 5'd15;
	localparam logic [4:0] REG_R16_LPEN_HI   = 5'd16;
	localparam logic [4:0] REG_R17_LPEN_LO   = 5'd17;

	// programmed register image
	typedef struct packed {
		logic [7:0]           horz_total;
		logic [7:0]           horz_display;
		logic [7:0]           horz_syncpos;
		logic [3:0]           horz_pulse;
		logic [3:0]           vert_pulse;
		logic [6:0]           vert_total;
		logic [4:0]           vert_fraction;
		logic [6:0]           vert_display;
		logic [6:0]           vert_syncpos;
		logic [4:0]           max_scanline;
		logic [1:0]           cursor_mode;
		logic [4:0]           cursor_start_row;
		logic [4:0]           cursor_end_row;
		logic [FS_ADDR_W-1:0] start_address;
		logic [FS_ADDR_W-1:0] cursor_adr;
	} crtc_cfg_t;

	// one-clock timing events
	typedef struct packed {
		logic scanline_end;
		logic row_end;
		logic frame_end;
		logic first_line;
	} crtc_beat_t;

	typedef struct packed {
		logic [FS_ADDR_W-1:0] framestore_adr;
		logic [4:0]           scanline_row;
		logic                 display_en;
		logic                 h_sync;
		logic                 v_sync;
		logic                 cursor;
	} crtc_video_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic       adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/crtc_regfile.sv
// crtc register file: wishbone slave, 6845 register bank, readback and light pen latch
`default_nettype none

module crtc_regfile import crtc_pkg::*; #(
	parameter int FS_ADDR_W = crtc_pkg::FS_ADDR_W
) (
	input  logic                 char_clk,
	input  logic                 nRESET,
	input  wb_req_t              wb_req,
	output wb_rsp_t              wb_rsp,
	input  logic                 lpstb,
	input  logic [FS_ADDR_W-1:0] framestore_adr,
	output crtc_cfg_t            cfg
);

	// width of the address fields inside the register image
	localparam int CFG_W = crtc_pkg::FS_ADDR_W;

	crtc_cfg_t            cfg_q;
	logic [4:0]           index;
	logic                 ack;
	logic [7:0]           rd_dat;
	logic [7:0]           rd_val;
	logic                 bus_hit;
	logic                 lp_meta;
	logic                 lp_sync;
	logic                 lp_rise;
	logic [FS_ADDR_W-1:0] lpen_adr;
	logic [15:0]          cur16;
	logic [15:0]          lp16;

	// new cycle seen while ack is low
	assign bus_hit = wb_req.cyc & wb_req.stb & ~ack;

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			ack <= 1'b0;
		end else begin
			ack <= bus_hit;
		end
	end

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			index <= '0;
			cfg_q <= '0;
		end else if (bus_hit && wb_req.we) begin
			if (!wb_req.adr) begin
				index <= wb_req.dat[4:0];
			end else begin
				// light pen and unused indices ignore writes
				case (index)
					REG_R0_HTOTAL:     cfg_q.horz_total   <= wb_req.dat;
					REG_R1_HDISP:      cfg_q.horz_display <= wb_req.dat;
					REG_R2_HSYNCPOS:   cfg_q.horz_syncpos <= wb_req.dat;
					REG_R3_SYNCWIDTH:  {cfg_q.vert_pulse, cfg_q.horz_pulse} <= wb_req.dat;
					REG_R4_VTOTAL:     cfg_q.vert_total    <= wb_req.dat[6:0];
					REG_R5_VTADJ:      cfg_q.vert_fraction <= wb_req.dat[4:0];
					REG_R6_VDISP:      cfg_q.vert_display  <= wb_req.dat[6:0];
					REG_R7_VSYNCPOS:   cfg_q.vert_syncpos  <= wb_req.dat[6:0];
					REG_R9_MAXSCAN:    cfg_q.max_scanline  <= wb_req.dat[4:0];
					REG_R10_CUR_START: begin
						cfg_q.cursor_mode      <= wb_req.dat[6:5];
						cfg_q.cursor_start_row <= wb_req.dat[4:0];
					end
					REG_R11_CUR_END:   cfg_q.cursor_end_row <= wb_req.dat[4:0];
					REG_R12_START_HI:
						cfg_q.start_address <= CFG_W'({wb_req.dat, cfg_q.start_address[7:0]});
					REG_R13_START_LO:  cfg_q.start_address[7:0] <= wb_req.dat;
					REG_R14_CUR_HI:
						cfg_q.cursor_adr <= CFG_W'({wb_req.dat, cfg_q.cursor_adr[7:0]});
					REG_R15_CUR_LO:    cfg_q.cursor_adr[7:0] <= wb_req.dat;
					default: ;
				endcase
			end
		end
	end

	assign cur16 = 16'(cfg_q.cursor_adr);
	assign lp16  = 16'(lpen_adr);

	// only cursor and light pen read back
	always_comb begin
		rd_val = '0;
		if (!wb_req.adr) begin
			rd_val = {3'b000, index};
		end else begin
			case (index)
				REG_R14_CUR_HI:  rd_val = cur16[15:8];
				REG_R15_CUR_LO:  rd_val = cur16[7:0];
				REG_R16_LPEN_HI: rd_val = lp16[15:8];
				REG_R17_LPEN_LO: rd_val = lp16[7:0];
				default:         rd_val = '0;
			endcase
		end
	end

	always_ff @(posedge char_clk) begin
		if (bus_hit && !wb_req.we) begin
			rd_dat <= rd_val;
		end
	end

	// lpstb is asynchronous
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			lp_meta <= 1'b0;
			lp_sync <= 1'b0;
		end else begin
			lp_meta <= lpstb;
			lp_sync <= lp_meta;
		end
	end

	assign lp_rise = lp_meta & ~lp_sync;

	always_ff @(posedge char_clk) begin
		if (lp_rise) begin
			lpen_adr <= framestore_adr;
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;
	assign cfg        = cfg_q;

endmodule

`default_nettype wire

// File: hdl/crtc_timing.sv
// crtc timing: horizontal and vertical counters, syncs, display enable and frame events
`default_nettype none

module crtc_timing import crtc_pkg::*; #(
	parameter int FS_ADDR_W = crtc_pkg::FS_ADDR_W
) (
	input  logic       char_clk,
	input  logic       nRESET,
	input  crtc_cfg_t  cfg,
	output crtc_beat_t beat,
	output logic       display_en,
	output logic       h_sync,
	output logic       v_sync
);

	logic [7:0] h_cnt;
	logic [7:0] h_nxt;
	logic [3:0] hp_cnt;
	logic [4:0] sl_cnt;
	logic [6:0] row_cnt;
	logic [4:0] adj_cnt;
	logic       adj_phase;
	logic [3:0] vp_cnt;

	logic scanline_end;
	logic last_sl;
	logic last_row;
	logic row_end;
	logic adj_end;
	logic frame_end;
	logic v_start;
	logic row_shown;

	// horizontal
	assign scanline_end = (h_cnt == cfg.horz_total);
	assign h_nxt        = scanline_end ? 8'd0 : h_cnt + 8'd1;

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_nxt;
		end
	end

	// pulse starts on the clock whose column equals the sync position
	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			h_sync <= 1'b0;
			hp_cnt <= '0;
		end else if (h_nxt == cfg.horz_syncpos && cfg.horz_pulse != 4'd0) begin
			h_sync <= 1'b1;
			hp_cnt <= 4'd1;
		end else if (h_sync) begin
			if (hp_cnt == cfg.horz_pulse) begin
				h_sync <= 1'b0;
			end else begin
				hp_cnt <= hp_cnt + 4'd1;
			end
		end
	end

	// vertical
	assign last_sl   = (sl_cnt == cfg.max_scanline);
	assign last_row  = (row_cnt == cfg.vert_total);
	assign row_end   = scanline_end & last_sl & ~adj_phase;
	assign adj_end   = (adj_cnt + 5'd1 == cfg.vert_fraction);

	// frame ends after the last row, or after the total adjust scanlines
	assign frame_end = scanline_end & (adj_phase ? adj_end :
		(last_sl & last_row & (cfg.vert_fraction == 5'd0)));

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			sl_cnt    <= '0;
			row_cnt   <= '0;
			adj_cnt   <= '0;
			adj_phase <= 1'b0;
		end else if (frame_end) begin
			sl_cnt    <= '0;
			row_cnt   <= '0;
			adj_cnt   <= '0;
			adj_phase <= 1'b0;
		end else if (scanline_end) begin
			if (adj_phase) begin
				adj_cnt <= adj_cnt + 5'd1;
			end else if (last_sl) begin
				sl_cnt <= '0;
				if (last_row) begin
					adj_phase <= 1'b1;
				end else begin
					row_cnt <= row_cnt + 7'd1;
				end
			end else begin
				sl_cnt <= sl_cnt + 5'd1;
			end
		end
	end

	// next scanline begins row vert_syncpos
	assign v_start = (frame_end & (cfg.vert_syncpos == 7'd0)) |
		(row_end & ~last_row & (row_cnt + 7'd1 == cfg.vert_syncpos));

	always_ff @(posedge char_clk) begin
		if (!nRESET) begin
			v_sync <= 1'b0;
			vp_cnt <= '0;
		end else if (scanline_end) begin
			if (v_start && cfg.vert_pulse != 4'd0) begin
				v_sync <= 1'b1;
				vp_cnt <= 4'd1;
			end else if (v_sync) begin
				if (vp_cnt == cfg.vert_pulse) begin
					v_sync <= 1'b0;
				end else begin
					vp_cnt <= vp_cnt + 4'd1;
				end
			end
		end
	end

	assign row_shown  = ~adj_phase & (row_cnt < cfg.vert_display);
	assign display_en = row_shown & (h_cnt < cfg.horz_display);

	assign beat.scanline_end = scanline_end;
	assign beat.row_end      = row_end;
	assign beat.frame_end    = frame_end;
	// first clock of a frame
	assign beat.first_line   = (h_cnt == 8'd0) & (sl_cnt == 5'd0) &
		(row_cnt == 7'd0) & ~adj_phase;

endmodule

`default_nettype wire

// File: hdl/crtc_top.sv
// crtc top level: register file, timing generator and address generator
`default_nettype none

module crtc_top import crtc_pkg::*; #(
	parameter int FS_ADDR_W = crtc_pkg::FS_ADDR_W
) (
	input  logic        char_clk,
	input  logic        nRESET,
	input  wb_req_t     wb_req,
	output wb_rsp_t     wb_rsp,
	input  logic        lpstb,
	output crtc_video_t video
);

	localparam int VID_W = crtc_pkg::FS_ADDR_W;

	crtc_cfg_t            cfg;
	crtc_beat_t           beat;
	logic                 display_en;
	logic                 h_sync;
	logic                 v_sync;
	logic [FS_ADDR_W-1:0] framestore_adr;
	logic [4:0]           scanline_row;
	logic                 cursor;

	crtc_regfile #(.FS_ADDR_W(FS_ADDR_W)) regfile_i (
		.char_clk       (char_clk),
		.nRESET         (nRESET),
		.wb_req         (wb_req),
		.wb_rsp         (wb_rsp),
		.lpstb          (lpstb),
		.framestore_adr (framestore_adr),
		.cfg            (cfg)
	);

	crtc_timing #(.FS_ADDR_W(FS_ADDR_W)) timing_i (
		.char_clk   (char_clk),
		.nRESET     (nRESET),
		.cfg        (cfg),
		.beat       (beat),
		.display_en (display_en),
		.h_sync     (h_sync),
		.v_sync     (v_sync)
	);

	crtc_address #(.FS_ADDR_W(FS_ADDR_W)) address_i (
		.char_clk       (char_clk),
		.nRESET         (nRESET),
		.cfg            (cfg),
		.beat           (beat),
		.display_en     (display_en),
		.framestore_adr (framestore_adr),
		.scanline_row   (scanline_row),
		.cursor         (cursor)
	);

	assign video.framestore_adr = VID_W'(framestore_adr);
	assign video.scanline_row   = scanline_row;
	assign video.display_en     = display_en;
	assign video.h_sync         = h_sync;
	assign video.v_sync         = v_sync;
	assign video.cursor         = cursor;

endmodule

`default_nettype wire

// File: verification/crtc_checks.sv
// crtc monitor: rebuilds sync, display and address expectations from the shadow registers
`default_nettype none

module crtc_checks import crtc_pkg::*; (
	input  logic        char_clk,
	input  logic        nRESET,
	input  logic        active,
	input  crtc_cfg_t   shadow,
	input  crtc_video_t video,
	output logic        mon_fail
);

	int                   cyc = 0;
	int                   h_last, v_last, hs_len, vs_len, de_len, lines, row;
	bit                   have_h, have_v, have_de, armed, in_frame;
	logic                 prev_hs = 1'b0;
	logic                 prev_vs = 1'b0;
	logic                 prev_de = 1'b0;
	logic                 exp_cur;
	logic [FS_ADDR_W-1:0] frame_start, exp_adr;
	logic [4:0]           exp_row;

	function automatic int line_clocks(input crtc_cfg_t c);
		return int'(c.horz_total) + 1;
	endfunction

	// character rows, then the total adjust scanlines
	function automatic int frame_lines(input crtc_cfg_t c);
		return (int'(c.vert_total) + 1) * (int'(c.max_scanline) + 1) + int'(c.vert_fraction);
	endfunction

	function automatic int shown_lines(input crtc_cfg_t c);
		return int'(c.vert_display) * (int'(c.max_scanline) + 1);
	endfunction

	task automatic mismatch(input string name, input int exp, input int act);
		$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
			$time, name, exp, act);
		mon_fail = 1'b1;
	endtask

	always @(posedge char_clk) begin
		cyc = cyc + 1;
		if (!nRESET || !active) begin
			have_h   = 0;
			have_v   = 0;
			have_de  = 0;
			armed    = 0;
			in_frame = 0;
			if (!nRESET)
				mon_fail = 1'b0;
		end else begin
			// horizontal sync period and width
			if (video.h_sync && !prev_hs) begin
				if (have_h)
					assert (cyc - h_last == line_clocks(shadow))
					else mismatch("h_sync period", line_clocks(shadow), cyc - h_last);
				h_last = cyc;
				have_h = 1;
				hs_len = 0;
			end
			if (video.h_sync)
				hs_len = hs_len + 1;
			if (!video.h_sync && prev_hs && have_h)
				assert (hs_len == int'(shadow.horz_pulse))
				else mismatch("h_sync width", int'(shadow.horz_pulse), hs_len);

			// vertical sync: frame length, pulse width, displayed scanlines
			if (video.v_sync && !prev_vs) begin
				if (have_v)
					assert (cyc - v_last == frame_lines(shadow) * line_clocks(shadow))
					else mismatch("v_sync period",
						frame_lines(shadow) * line_clocks(shadow), cyc - v_last);
				if (in_frame)
					assert (lines == shown_lines(shadow))
					else mismatch("display_en scanlines", shown_lines(shadow), lines);
				v_last   = cyc;
				have_v   = 1;
				vs_len   = 0;
				armed    = 1;
				in_frame = 0;
			end
			if (video.v_sync)
				vs_len = vs_len + 1;
			if (!video.v_sync && prev_vs && have_v)
				assert (vs_len == int'(shadow.vert_pulse) * line_clocks(shadow))
				else mismatch("v_sync width",
					int'(shadow.vert_pulse) * line_clocks(shadow), vs_len);

			// start of a displayed scanline
			if (video.display_en && !prev_de) begin
				if (armed) begin
					armed       = 0;
					in_frame    = 1;
					lines       = 0;
					frame_start = shadow.start_address;
				end
				if (in_frame) begin
					row     = lines / (int'(shadow.max_scanline) + 1);
					exp_row = 5'(lines % (int'(shadow.max_scanline) + 1));
					exp_adr = frame_start + FS_ADDR_W'(row * int'(shadow.horz_display));
					lines   = lines + 1;
				end
				have_de = 1;
				de_len  = 0;
			end
			if (video.display_en)
				de_len = de_len + 1;
			if (!video.display_en && prev_de && have_de)
				assert (de_len == int'(shadow.horz_display))
				else mismatch("display_en width", int'(shadow.horz_display), de_len);

			// addressing and cursor on displayed characters
			if (video.display_en && in_frame) begin
				assert (video.framestore_adr == exp_adr)
				else mismatch("framestore_adr", int'(exp_adr), int'(video.framestore_adr));
				assert (video.scanline_row == exp_row)
				else mismatch("scanline_row", int'(exp_row), int'(video.scanline_row));
				exp_cur = (exp_adr == shadow.cursor_adr) && (shadow.cursor_mode != 2'b01) &&
					(exp_row >= shadow.cursor_start_row) && (exp_row <= shadow.cursor_end_row);
				assert (video.cursor == exp_cur)
				else mismatch("cursor", int'(exp_cur), int'(video.cursor));
				exp_adr = exp_adr + FS_ADDR_W'(1);
			end else if (!video.display_en) begin
				assert (!video.cursor)
				else mismatch("cursor", 0, int'(video.cursor));
			end
		end
		prev_hs = video.h_sync;
		prev_vs = video.v_sync;
		prev_de = video.display_en;
	end

endmodule

`default_nettype wire

// File: verification/crtc_tb.sv
// crtc testbench: clock, reset, wishbone host, register programming and run control
`default_nettype none

module crtc_tb import crtc_pkg::*; ();

	// small screen: 20 clocks per scanline, 30 scanlines per frame
	localparam int LINE_CLKS  = 20;
	localparam int FRAME_CLKS = ((6 + 1) * (3 + 1) + 2) * LINE_CLKS;
	// bus traffic and light pen test
	localparam int PROG_CLKS  = 400;
	// one warm-up frame plus five checked frames
	localparam int LIMIT      = 6 * FRAME_CLKS + PROG_CLKS;

	logic        char_clk;
	logic        nRESET;
	logic        lpstb;
	logic        active;
	logic        mon_fail;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	crtc_video_t video;
	crtc_cfg_t   shadow;
	int          seed;
	int          cycles;
	logic [7:0]  rd;
	logic [15:0] lp_exp;

	crtc_top #(.FS_ADDR_W(FS_ADDR_W)) dut_i (
		.char_clk (char_clk),
		.nRESET   (nRESET),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.lpstb    (lpstb),
		.video    (video)
	);

	crtc_checks checks_i (
		.char_clk (char_clk),
		.nRESET   (nRESET),
		.active   (active),
		.shadow   (shadow),
		.video    (video),
		.mon_fail (mon_fail)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic expect_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act == exp) else begin
			$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, exp, act);
			abort_run("register readback differs from the expected value");
		end
	endtask

	// one classic cycle, held until ack
	task automatic bus_access(input logic we, input logic adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
		int waited;
		waited = 0;
		@(posedge char_clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= we;
		wb_req.adr <= adr;
		wb_req.dat <= wdat;
		do begin
			@(posedge char_clk);
			waited = waited + 1;
			if (waited > 8)
				abort_run("no ack from the Wishbone slave");
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		wb_req <= '0;
		@(posedge char_clk);
		assert (!wb_rsp.ack) else
			abort_run("ack stayed high for more than one cycle");
	endtask

	task automatic reg_write(input logic [4:0] idx, input logic [7:0] val);
		logic [7:0] unused;
		bus_access(1'b1, 1'b0, {3'b000, idx}, unused);
		bus_access(1'b1, 1'b1, val, unused);
	endtask

	task automatic reg_read(input logic [4:0] idx, output logic [7:0] val);
		logic [7:0] unused;
		bus_access(1'b1, 1'b0, {3'b000, idx}, unused);
		bus_access(1'b0, 1'b1, 8'h00, val);
	endtask

	task automatic set_start(input logic [FS_ADDR_W-1:0] adr);
		reg_write(REG_R12_START_HI, 8'(16'(adr) >> 8));
		reg_write(REG_R13_START_LO, adr[7:0]);
		shadow.start_address = adr;
	endtask

	task automatic wait_vsync(input int n);
		repeat (n) @(posedge video.v_sync);
	endtask

	initial begin
		char_clk = 1'b0;
		forever #50 char_clk = ~char_clk;
	end

	always @(posedge char_clk) begin
		cycles = cycles + 1;
		if (cycles > LIMIT)
			abort_run("timeout: the frames did not complete in the expected time");
	end

	always @(posedge mon_fail)
		abort_run("video monitor found a mismatch");

	initial begin
		seed   = 70;
		cycles = 0;
		nRESET = 1'b0;
		lpstb  = 1'b0;
		active = 1'b0;
		wb_req = '0;
		shadow = '0;
		repeat (2) @(posedge char_clk);
		nRESET <= 1'b1;
		@(posedge char_clk);
		assert (!wb_rsp.ack) else
			abort_run("ack is high after reset");

		reg_write(REG_R0_HTOTAL, 8'd19);
		reg_write(REG_R1_HDISP, 8'd12);
		reg_write(REG_R2_HSYNCPOS, 8'd14);
		// vert pulse 2, horz pulse 3
		reg_write(REG_R3_SYNCWIDTH, 8'h23);
		reg_write(REG_R4_VTOTAL, 8'd6);
		reg_write(REG_R5_VTADJ, 8'd2);
		reg_write(REG_R6_VDISP, 8'd4);
		reg_write(REG_R7_VSYNCPOS, 8'd5);
		reg_write(REG_R9_MAXSCAN, 8'd3);
		reg_write(REG_R10_CUR_START, 8'h01);
		reg_write(REG_R11_CUR_END, 8'd2);
		shadow.horz_total       = 8'd19;
		shadow.horz_display     = 8'd12;
		shadow.horz_syncpos     = 8'd14;
		shadow.horz_pulse       = 4'd3;
		shadow.vert_pulse       = 4'd2;
		shadow.vert_total       = 7'd6;
		shadow.vert_fraction    = 5'd2;
		shadow.vert_display     = 7'd4;
		shadow.vert_syncpos     = 7'd5;
		shadow.max_scanline     = 5'd3;
		shadow.cursor_mode      = 2'b00;
		shadow.cursor_start_row = 5'd1;
		shadow.cursor_end_row   = 5'd2;
		set_start(FS_ADDR_W'($random(seed)));
		// row 2, column 5 of the visible area
		shadow.cursor_adr = shadow.start_address + FS_ADDR_W'(2 * 12 + 5);
		reg_write(REG_R14_CUR_HI, 8'(16'(shadow.cursor_adr) >> 8));
		reg_write(REG_R15_CUR_LO, shadow.cursor_adr[7:0]);

		reg_read(REG_R14_CUR_HI, rd);
		expect_byte("R14", 8'(16'(shadow.cursor_adr) >> 8), rd);
		reg_read(REG_R15_CUR_LO, rd);
		expect_byte("R15", shadow.cursor_adr[7:0], rd);
		bus_access(1'b0, 1'b0, 8'h00, rd);
		expect_byte("index", {3'b000, REG_R15_CUR_LO}, rd);
		reg_read(REG_R0_HTOTAL, rd);
		expect_byte("R0", 8'h00, rd);

		active <= 1'b1;
		wait_vsync(2);

		// light pen strobe while the screen scans
		@(posedge char_clk);
		lpstb <= 1'b1;
		@(posedge char_clk);
		@(negedge char_clk);
		lp_exp = 16'(video.framestore_adr);
		@(posedge char_clk);
		lpstb <= 1'b0;
		reg_read(REG_R16_LPEN_HI, rd);
		expect_byte("R16", lp_exp[15:8], rd);
		reg_read(REG_R17_LPEN_LO, rd);
		expect_byte("R17", lp_exp[7:0], rd);

		wait_vsync(2);
		// display is blanked from the sync row to the frame end
		reg_write(REG_R10_CUR_START, 8'h21);
		shadow.cursor_mode = 2'b01;
		set_start(FS_ADDR_W'($random(seed)));
		wait_vsync(2);
		// the monitor sees the last sync edge one clock later
		repeat (2) @(negedge char_clk);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/crtc_pkg.sv
hdl/crtc_regfile.sv
hdl/crtc_timing.sv
hdl/crtc_address.sv
hdl/crtc_top.sv
verification/crtc_checks.sv
verification/crtc_tb.sv
